// File: rvPkg.sv
package rvPkg;

   localparam int aluOpW = 4;
   localparam int selW = 2;

   // major opcodes of the supported RV32I subset
   localparam logic [6:0] opOp = 7'b0110011;
   localparam logic [6:0] opOpImm = 7'b0010011;
   localparam logic [6:0] opLui = 7'b0110111;
   localparam logic [6:0] opLoad = 7'b0000011;
   localparam logic [6:0] opStore = 7'b0100011;
   localparam logic [6:0] opBranch = 7'b1100011;
   localparam logic [6:0] opJal = 7'b1101111;
   localparam logic [6:0] opJalr = 7'b1100111;
   localparam logic [6:0] opSystem = 7'b1110011;

   localparam logic [aluOpW-1:0] aluAdd = 4'd0;
   localparam logic [aluOpW-1:0] aluSub = 4'd1;
   localparam logic [aluOpW-1:0] aluAnd = 4'd2;
   localparam logic [aluOpW-1:0] aluOr = 4'd3;
   localparam logic [aluOpW-1:0] aluXor = 4'd4;
   localparam logic [aluOpW-1:0] aluSlt = 4'd5;
   localparam logic [aluOpW-1:0] aluPassB = 4'd6;

   // write-back source
   localparam logic [selW-1:0] wbAlu = 2'd0;
   localparam logic [selW-1:0] wbMem = 2'd1;
   localparam logic [selW-1:0] wbLink = 2'd2;

   // execute operand source
   localparam logic [selW-1:0] fwdReg = 2'd0;
   localparam logic [selW-1:0] fwdExMem = 2'd1;
   localparam logic [selW-1:0] fwdMemWb = 2'd2;

   localparam logic [selW-1:0] brNone = 2'd0;
   localparam logic [selW-1:0] brEq = 2'd1;
   localparam logic [selW-1:0] brNe = 2'd2;
   localparam logic [selW-1:0] brLt = 2'd3;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rFmt;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } iFmt;

   typedef struct packed {
      logic [6:0] immHi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] immLo;
      logic [6:0] opcode;
   } sFmt;

   // branch offset bits are scattered, bit 0 is implied zero
   typedef struct packed {
      logic bit12;
      logic [5:0] bits10to5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] bits4to1;
      logic bit11;
      logic [6:0] opcode;
   } bFmt;

   typedef struct packed {
      logic [19:0] imm;
      logic [4:0] rd;
      logic [6:0] opcode;
   } uFmt;

   typedef struct packed {
      logic bit20;
      logic [9:0] bits10to1;
      logic bit11;
      logic [7:0] bits19to12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } jFmt;

   typedef union packed {
      rFmt rType;
      iFmt iType;
      sFmt sType;
      bFmt bType;
      uFmt uType;
      jFmt jType;
   } instrWord;

endpackage

// File: fwdIf.sv
`timescale 1ns/10ps

interface fwdIf;
   import rvPkg::*;

   logic [4:0] idRs1, idRs2;
   logic [4:0] exRs1, exRs2;
   logic [4:0] exMemRd, memWbRd;
   logic exMemWe, memWbWe;
   logic [selW-1:0] fwdA, fwdB;
   logic bypassA, bypassB;

   modport datapath (
      output idRs1, idRs2, exRs1, exRs2, exMemRd, exMemWe, memWbRd, memWbWe,
      input fwdA, fwdB, bypassA, bypassB
   );

   modport forward (
      input idRs1, idRs2, exRs1, exRs2, exMemRd, exMemWe, memWbRd, memWbWe,
      output fwdA, fwdB, bypassA, bypassB
   );

endinterface

// File: rvDecode.sv
`timescale 1ns/10ps

module rvDecode (
   input rvPkg::instrWord instr,
   output logic [rvPkg::aluOpW-1:0] aluOp,
   output logic srcAPc,
   output logic srcBImm,
   output logic [31:0] imm,
   output logic [rvPkg::selW-1:0] wbSel,
   output logic regWe,
   output logic memRead,
   output logic memWrite,
   output logic [rvPkg::selW-1:0] brKind,
   output logic isJal,
   output logic isJalr,
   output logic isEcall
);
   import rvPkg::*;

   logic [aluOpW-1:0] funcOp;
   logic writesRd;

   // funct3 picks the operation for both register and immediate forms
   always_comb begin
      case (instr.rType.funct3)
         3'b111: funcOp = aluAnd;
         3'b110: funcOp = aluOr;
         3'b100: funcOp = aluXor;
         3'b010: funcOp = aluSlt;
         default: funcOp = aluAdd;
      endcase
   end

   always_comb begin
      aluOp = aluAdd;
      srcAPc = 1'b0;
      srcBImm = 1'b0;
      imm = '0;
      wbSel = wbAlu;
      writesRd = 1'b0;
      memRead = 1'b0;
      memWrite = 1'b0;
      brKind = brNone;
      isJal = 1'b0;
      isJalr = 1'b0;
      isEcall = 1'b0;
      case (instr.rType.opcode)
         opOp: begin
            aluOp = (instr.rType.funct3 == 3'b000 && instr.rType.funct7[5]) ? aluSub : funcOp;
            writesRd = 1'b1;
         end
         opOpImm: begin
            aluOp = funcOp;
            srcBImm = 1'b1;
            imm = {{20{instr.iType.imm[11]}}, instr.iType.imm};
            writesRd = 1'b1;
         end
         opLui: begin
            aluOp = aluPassB;
            srcBImm = 1'b1;
            imm = {instr.uType.imm, 12'b0};
            writesRd = 1'b1;
         end
         opLoad: begin
            srcBImm = 1'b1;
            imm = {{20{instr.iType.imm[11]}}, instr.iType.imm};
            memRead = 1'b1;
            wbSel = wbMem;
            writesRd = 1'b1;
         end
         opStore: begin
            srcBImm = 1'b1;
            imm = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
            memWrite = 1'b1;
         end
         // alu forms the target pc + offset, the comparator decides
         opBranch: begin
            srcAPc = 1'b1;
            srcBImm = 1'b1;
            imm = {{19{instr.bType.bit12}}, instr.bType.bit12, instr.bType.bit11,
                   instr.bType.bits10to5, instr.bType.bits4to1, 1'b0};
            case (instr.bType.funct3)
               3'b000: brKind = brEq;
               3'b001: brKind = brNe;
               3'b100: brKind = brLt;
               default: brKind = brNone;
            endcase
         end
         opJal: begin
            srcAPc = 1'b1;
            srcBImm = 1'b1;
            imm = {{11{instr.jType.bit20}}, instr.jType.bit20, instr.jType.bits19to12,
                   instr.jType.bit11, instr.jType.bits10to1, 1'b0};
            wbSel = wbLink;
            writesRd = 1'b1;
            isJal = 1'b1;
         end
         opJalr: begin
            srcBImm = 1'b1;
            imm = {{20{instr.iType.imm[11]}}, instr.iType.imm};
            wbSel = wbLink;
            writesRd = 1'b1;
            isJalr = 1'b1;
         end
         opSystem: isEcall = 1'b1;
         // anything else passes through as a bubble
         default: ;
      endcase
   end

   // x0 is never a destination
   assign regWe = writesRd && (instr.rType.rd != 5'd0);

endmodule

// File: rvAlu.sv
`timescale 1ns/10ps

module rvAlu (
   input logic [31:0] a,
   input logic [31:0] b,
   input logic [rvPkg::aluOpW-1:0] op,
   input logic [31:0] brA,
   input logic [31:0] brB,
   input logic [rvPkg::selW-1:0] brKind,
   output logic [31:0] result,
   output logic brTaken
);
   import rvPkg::*;

   always_comb begin
      case (op)
         aluSub: result = a - b;
         aluAnd: result = a & b;
         aluOr: result = a | b;
         aluXor: result = a ^ b;
         aluSlt: result = {31'b0, $signed(a) < $signed(b)};
         aluPassB: result = b;
         default: result = a + b;
      endcase
   end

   // comparator runs beside the adder, which builds the target
   always_comb begin
      case (brKind)
         brEq: brTaken = (brA == brB);
         brNe: brTaken = (brA != brB);
         brLt: brTaken = ($signed(brA) < $signed(brB));
         default: brTaken = 1'b0;
      endcase
   end

endmodule

// File: rvForward.sv
`timescale 1ns/10ps

module rvForward (
   fwdIf.forward fwd
);
   import rvPkg::*;

   function automatic logic hits(input logic [4:0] rs, input logic [4:0] rd, input logic we);
      return we && (rd != 5'd0) && (rd == rs);
   endfunction

   // memory stage holds the younger result, so it wins
   function automatic logic [selW-1:0] pickSrc(input logic [4:0] rs);
      if (hits(rs, fwd.exMemRd, fwd.exMemWe)) begin
         return fwdExMem;
      end else if (hits(rs, fwd.memWbRd, fwd.memWbWe)) begin
         return fwdMemWb;
      end
      return fwdReg;
   endfunction

   always_comb begin
      fwd.fwdA = pickSrc(fwd.exRs1);
      fwd.fwdB = pickSrc(fwd.exRs2);
   end

   // register file write lands at the edge, decode needs it now
   assign fwd.bypassA = hits(fwd.idRs1, fwd.memWbRd, fwd.memWbWe);
   assign fwd.bypassB = hits(fwd.idRs2, fwd.memWbRd, fwd.memWbWe);

endmodule

// File: rvRunCtrl.sv
`timescale 1ns/10ps

module rvRunCtrl (
   input logic clk,
   input logic rstN,
   input logic wbValid,
   input logic wbIsEcall,
   output logic run,
   output logic halt,
   output logic [31:0] numInst
);

   localparam logic stRunning = 1'b0;
   localparam logic stHalted = 1'b1;

   logic state;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state <= stRunning;
         numInst <= '0;
      end else if (state == stRunning && wbValid) begin
         // ecall retires without being counted
         if (wbIsEcall) begin
            state <= stHalted;
         end else begin
            numInst <= numInst + 32'd1;
         end
      end
   end

   // halted is terminal until reset
   assign run = (state == stRunning);
   assign halt = (state == stHalted);

endmodule

// File: rvDatapath.sv
`timescale 1ns/10ps

module rvDatapath #(
   parameter int addrW = 12
) (
   input logic clk,
   input logic rstN,
   input logic [31:0] iMemDi,
   input logic [31:0] dMemDi,
   input logic [31:0] rfRd1,
   input logic [31:0] rfRd2,
   input logic run,
   output logic [addrW-1:0] iMemAddr,
   output logic [addrW-1:0] dMemAddr,
   output logic [31:0] dMemDout,
   output logic dMemWen,
   output logic [3:0] dMemBe,
   output logic [4:0] rfRa1,
   output logic [4:0] rfRa2,
   output logic [4:0] rfWa,
   output logic rfWe,
   output logic [31:0] rfWd,
   output logic wbValid,
   output logic wbIsEcall,
   output logic [31:0] outputPort,
   fwdIf.datapath fwd
);
   import rvPkg::*;

   logic [31:0] pc;
   logic ifIdValid;
   logic [31:0] ifIdPc;
   instrWord ifIdInstr;

   // decode stage
   logic [aluOpW-1:0] idAluOp;
   logic [31:0] idImm, idRs1Val, idRs2Val;
   logic [selW-1:0] idWbSel, idBrKind;
   logic idSrcAPc, idSrcBImm, idRegWe, idMemRead, idMemWrite;
   logic idIsJal, idIsJalr, idIsEcall;

   // ID/EX
   logic exValid;
   logic [31:0] exPc, exImm, exRs1Val, exRs2Val;
   logic [4:0] exRs1, exRs2, exRd;
   logic [aluOpW-1:0] exAluOp;
   logic [selW-1:0] exWbSrc, exBrKind;
   logic exSrcAPc, exSrcBImm, exRegWe, exMemRead, exMemWrite;
   logic exIsJal, exIsJalr, exIsEcall;
   logic [31:0] opA, opB, aluA, aluB, aluRes, target;
   logic brTaken, redirect, flush;

   // EX/MEM
   logic memValid, memRegWe, memIsStore, memIsLoad, memEcall, memBranch, memTaken;
   logic [31:0] memAluRes, memStoreData, memLinkAddr, memFwdVal;
   logic [4:0] memRd;
   logic [selW-1:0] memSrc;

   // MEM/WB
   logic wbRegWe, wbStore, wbBranch, wbTaken;
   logic [31:0] wbAluRes, wbMemData, wbLinkAddr;
   logic [4:0] wbRd;
   logic [selW-1:0] wbSrc;

   function automatic logic [31:0] wbMux(input logic [selW-1:0] sel, input logic [31:0] aluVal,
                                         input logic [31:0] memVal, input logic [31:0] linkVal);
      case (sel)
         wbMem: return memVal;
         wbLink: return linkVal;
         default: return aluVal;
      endcase
   endfunction

   function automatic logic [31:0] pickOperand(input logic [selW-1:0] sel,
                                               input logic [31:0] regVal,
                                               input logic [31:0] memVal,
                                               input logic [31:0] wbVal);
      case (sel)
         fwdExMem: return memVal;
         fwdMemWb: return wbVal;
         default: return regVal;
      endcase
   endfunction

   // fetch, pc holds still once the core has halted
   assign iMemAddr = pc[addrW-1:0];

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc <= '0;
      end else if (run) begin
         pc <= redirect ? target : pc + 32'd4;
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         ifIdValid <= 1'b0;
         exValid <= 1'b0;
      end else begin
         ifIdValid <= run && !flush;
         exValid <= ifIdValid && !flush;
      end
   end

   always_ff @(posedge clk) begin
      ifIdInstr <= iMemDi;
      ifIdPc <= pc;
   end

   rvDecode uDecode (
      .instr(ifIdInstr),
      .aluOp(idAluOp),
      .srcAPc(idSrcAPc),
      .srcBImm(idSrcBImm),
      .imm(idImm),
      .wbSel(idWbSel),
      .regWe(idRegWe),
      .memRead(idMemRead),
      .memWrite(idMemWrite),
      .brKind(idBrKind),
      .isJal(idIsJal),
      .isJalr(idIsJalr),
      .isEcall(idIsEcall)
   );

   assign rfRa1 = ifIdInstr.rType.rs1;
   assign rfRa2 = ifIdInstr.rType.rs2;
   assign fwd.idRs1 = rfRa1;
   assign fwd.idRs2 = rfRa2;
   assign idRs1Val = fwd.bypassA ? rfWd : rfRd1;
   assign idRs2Val = fwd.bypassB ? rfWd : rfRd2;

   always_ff @(posedge clk) begin
      exPc <= ifIdPc;
      exImm <= idImm;
      exRs1Val <= idRs1Val;
      exRs2Val <= idRs2Val;
      exRs1 <= ifIdInstr.rType.rs1;
      exRs2 <= ifIdInstr.rType.rs2;
      exRd <= ifIdInstr.rType.rd;
      exAluOp <= idAluOp;
      exSrcAPc <= idSrcAPc;
      exSrcBImm <= idSrcBImm;
      exWbSrc <= idWbSel;
      exRegWe <= idRegWe;
      exMemRead <= idMemRead;
      exMemWrite <= idMemWrite;
      exBrKind <= idBrKind;
      exIsJal <= idIsJal;
      exIsJalr <= idIsJalr;
      exIsEcall <= idIsEcall;
   end

   // execute, a load in memory forwards the word read this cycle
   assign fwd.exRs1 = exRs1;
   assign fwd.exRs2 = exRs2;
   assign memFwdVal = wbMux(memSrc, memAluRes, dMemDi, memLinkAddr);
   assign opA = pickOperand(fwd.fwdA, exRs1Val, memFwdVal, rfWd);
   assign opB = pickOperand(fwd.fwdB, exRs2Val, memFwdVal, rfWd);
   assign aluA = exSrcAPc ? exPc : opA;
   assign aluB = exSrcBImm ? exImm : opB;

   rvAlu uAlu (
      .a(aluA),
      .b(aluB),
      .op(exAluOp),
      .brA(opA),
      .brB(opB),
      .brKind(exBrKind),
      .result(aluRes),
      .brTaken(brTaken)
   );

   // ecall also kills the two younger slots so nothing behind it commits
   assign redirect = exValid && (exIsJal || exIsJalr || brTaken);
   assign flush = redirect || (exValid && exIsEcall);
   assign target = exIsJalr ? {aluRes[31:1], 1'b0} : aluRes;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         memValid <= 1'b0;
         memRegWe <= 1'b0;
         memIsStore <= 1'b0;
         memEcall <= 1'b0;
         memBranch <= 1'b0;
      end else begin
         memValid <= exValid;
         memRegWe <= exValid && exRegWe;
         memIsStore <= exValid && exMemWrite;
         memEcall <= exValid && exIsEcall;
         memBranch <= exValid && (exBrKind != brNone);
      end
   end

   always_ff @(posedge clk) begin
      memAluRes <= aluRes;
      memStoreData <= opB;
      memLinkAddr <= exPc + 32'd4;
      memRd <= exRd;
      memSrc <= exWbSrc;
      memIsLoad <= exMemRead;
      memTaken <= brTaken;
   end

   // memory, word addressed and always a full word
   assign dMemAddr = memAluRes[addrW+1:2];
   assign dMemDout = memStoreData;
   assign dMemWen = memIsStore && run;
   assign dMemBe = 4'b1111;
   assign fwd.exMemRd = memRd;
   assign fwd.exMemWe = memRegWe;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         wbValid <= 1'b0;
         wbRegWe <= 1'b0;
         wbStore <= 1'b0;
         wbBranch <= 1'b0;
         wbIsEcall <= 1'b0;
      end else begin
         wbValid <= memValid;
         wbRegWe <= memRegWe;
         wbStore <= memIsStore;
         wbBranch <= memBranch;
         wbIsEcall <= memEcall;
      end
   end

   always_ff @(posedge clk) begin
      wbAluRes <= memAluRes;
      wbLinkAddr <= memLinkAddr;
      wbRd <= memRd;
      wbSrc <= memSrc;
      wbTaken <= memTaken;
      if (memIsLoad) begin
         wbMemData <= dMemDi;
      end
   end

   // write-back
   assign rfWd = wbMux(wbSrc, wbAluRes, wbMemData, wbLinkAddr);
   assign rfWa = wbRd;
   assign rfWe = wbRegWe && run;
   assign fwd.memWbRd = wbRd;
   assign fwd.memWbWe = wbRegWe;

   // test port: written value, else store address, else branch outcome
   always_comb begin
      if (wbRegWe) begin
         outputPort = rfWd;
      end else if (wbStore) begin
         outputPort = wbAluRes;
      end else if (wbBranch) begin
         outputPort = {31'b0, wbTaken};
      end else begin
         outputPort = '0;
      end
   end

endmodule

// File: rvTop.sv
`timescale 1ns/10ps

module rvTop #(
   parameter int addrW = 12
) (
   input logic clk,
   input logic rstN,

   // instruction memory, byte address
   output logic iMemCsN,
   output logic [addrW-1:0] iMemAddr,
   input logic [31:0] iMemDi,

   // data memory, word address
   output logic dMemCsN,
   output logic [addrW-1:0] dMemAddr,
   input logic [31:0] dMemDi,
   output logic [31:0] dMemDout,
   output logic dMemWen,
   output logic [3:0] dMemBe,

   // register file
   output logic rfWe,
   output logic [4:0] rfRa1,
   output logic [4:0] rfRa2,
   output logic [4:0] rfWa,
   input logic [31:0] rfRd1,
   input logic [31:0] rfRd2,
   output logic [31:0] rfWd,

   output logic halt,
   output logic [31:0] numInst,
   output logic [31:0] outputPort
);

   logic run;
   logic wbValid;
   logic wbIsEcall;

   fwdIf fwdBus ();

   assign iMemCsN = ~rstN;
   assign dMemCsN = ~rstN;

   rvDatapath #(
      .addrW(addrW)
   ) uDatapath (
      .clk(clk),
      .rstN(rstN),
      .iMemDi(iMemDi),
      .dMemDi(dMemDi),
      .rfRd1(rfRd1),
      .rfRd2(rfRd2),
      .run(run),
      .iMemAddr(iMemAddr),
      .dMemAddr(dMemAddr),
      .dMemDout(dMemDout),
      .dMemWen(dMemWen),
      .dMemBe(dMemBe),
      .rfRa1(rfRa1),
      .rfRa2(rfRa2),
      .rfWa(rfWa),
      .rfWe(rfWe),
      .rfWd(rfWd),
      .wbValid(wbValid),
      .wbIsEcall(wbIsEcall),
      .outputPort(outputPort),
      .fwd(fwdBus.datapath)
   );

   rvForward uForward (
      .fwd(fwdBus.forward)
   );

   rvRunCtrl uRunCtrl (
      .clk(clk),
      .rstN(rstN),
      .wbValid(wbValid),
      .wbIsEcall(wbIsEcall),
      .run(run),
      .halt(halt),
      .numInst(numInst)
   );

endmodule

// File: tbTop.sv
`timescale 1ns/10ps

module tbTop;

   localparam int addrW = 12;
   localparam int iDepth = 2 ** (addrW - 2);
   localparam int dDepth = 2 ** addrW;
   localparam logic [6:0] opOp = 7'b0110011;
   localparam logic [6:0] opOpImm = 7'b0010011;
   localparam logic [6:0] opLui = 7'b0110111;
   localparam logic [6:0] opLoad = 7'b0000011;
   localparam logic [6:0] opStore = 7'b0100011;
   localparam logic [6:0] opBranch = 7'b1100011;
   localparam logic [6:0] opJal = 7'b1101111;
   localparam logic [6:0] opJalr = 7'b1100111;
   localparam logic [6:0] opSystem = 7'b1110011;

   logic clk;
   logic rstN;
   logic iMemCsN, dMemCsN, dMemWen, rfWe, halt;
   logic [addrW-1:0] iMemAddr, dMemAddr;
   logic [31:0] iMemDi, dMemDi, dMemDout, rfRd1, rfRd2, rfWd, numInst, outputPort;
   logic [3:0] dMemBe;
   logic [4:0] rfRa1, rfRa2, rfWa;

   // memory and register file models
   logic [31:0] imem [iDepth];
   logic [31:0] dmem [dDepth];
   logic [31:0] rf [32];

   // reference model state
   logic [31:0] mReg [32];
   logic [31:0] mMem [dDepth];
   logic [36:0] expWrites [$];
   logic [36:0] nextWr;
   logic [31:0] prog [$];
   logic [31:0] rngState;
   int mCount;
   int errors;
   int cycles;
   int limit;
   int testsRun;

   rvTop #(
      .addrW(addrW)
   ) uut (
      .clk(clk),
      .rstN(rstN),
      .iMemCsN(iMemCsN),
      .iMemAddr(iMemAddr),
      .iMemDi(iMemDi),
      .dMemCsN(dMemCsN),
      .dMemAddr(dMemAddr),
      .dMemDi(dMemDi),
      .dMemDout(dMemDout),
      .dMemWen(dMemWen),
      .dMemBe(dMemBe),
      .rfWe(rfWe),
      .rfRa1(rfRa1),
      .rfRa2(rfRa2),
      .rfWa(rfWa),
      .rfRd1(rfRd1),
      .rfRd2(rfRd2),
      .rfWd(rfWd),
      .halt(halt),
      .numInst(numInst),
      .outputPort(outputPort)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // combinational reads, x0 reads as zero
   assign iMemDi = imem[iMemAddr[addrW-1:2]];
   assign dMemDi = dmem[dMemAddr];
   assign rfRd1 = (rfRa1 == 5'd0) ? 32'd0 : rf[rfRa1];
   assign rfRd2 = (rfRa2 == 5'd0) ? 32'd0 : rf[rfRa2];

   always @(posedge clk) begin
      if (rfWe && rfWa != 5'd0) begin
         rf[rfWa] <= rfWd;
      end
      if (dMemWen) begin
         dmem[dMemAddr] <= dMemDout;
      end
   end

   function automatic logic [31:0] nextRand();
      rngState = rngState ^ (rngState << 13);
      rngState = rngState ^ (rngState >> 17);
      rngState = rngState ^ (rngState << 5);
      return rngState;
   endfunction

   function automatic logic [4:0] randReg(input int lo, input int n);
      return 5'(lo + int'(nextRand() % 32'(n)));
   endfunction

   function automatic logic [31:0] encR(input int f7, input int rs2, input int rs1,
                                        input int f3, input int rd);
      return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), opOp};
   endfunction

   function automatic logic [31:0] encI(input int imm, input int rs1, input int f3,
                                        input int rd, input logic [6:0] op);
      return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), op};
   endfunction

   function automatic logic [31:0] encS(input int imm, input int rs2, input int rs1);
      logic [11:0] v;
      v = 12'(imm);
      return {v[11:5], 5'(rs2), 5'(rs1), 3'b010, v[4:0], opStore};
   endfunction

   function automatic logic [31:0] encB(input int off, input int rs2, input int rs1,
                                        input int f3);
      logic [12:0] o;
      o = 13'(off);
      return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], opBranch};
   endfunction

   function automatic logic [31:0] encJ(input int off, input int rd);
      logic [20:0] o;
      o = 21'(off);
      return {o[20], o[10:1], o[11], o[19:12], 5'(rd), opJal};
   endfunction

   task automatic checkValue(input string name, input logic [31:0] expV,
                             input logic [31:0] actV);
      assert (expV === actV) else begin
         $display("Fail at %0t ns: %s expected %h actual %h", $time, name, expV, actV);
         errors++;
      end
   endtask

   task automatic noteFail(input string msg);
      $display("%0t ns: %s", $time, msg);
      errors++;
   endtask

   // stores carry whole words, nothing is written after halt
   assert property (@(posedge clk) disable iff (!rstN) dMemWen |-> dMemBe == 4'b1111)
      else noteFail("a store was issued without all byte enables set");
   assert property (@(posedge clk) disable iff (!rstN) halt |-> !rfWe && !dMemWen)
      else noteFail("a register or memory write was seen after halt");

   // the write sequence must follow the model in order
   always @(negedge clk) begin
      if (rstN && rfWe) begin
         if (expWrites.size() == 0) begin
            noteFail("register write seen that the reference model never made");
         end else begin
            nextWr = expWrites.pop_front();
            checkValue("rfWa", 32'(nextWr[36:32]), 32'(rfWa));
            checkValue("rfWd", nextWr[31:0], rfWd);
            checkValue("outputPort", nextWr[31:0], outputPort);
         end
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > limit) begin
         $display("timeout: the core did not halt within %0d cycles", limit);
         $display("Test failed");
         $finish;
      end
   end

   function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic subtract,
                                          input logic [31:0] a, input logic [31:0] b);
      case (f3)
         3'b000: return subtract ? a - b : a + b;
         3'b111: return a & b;
         3'b110: return a | b;
         3'b100: return a ^ b;
         3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         default: return 32'hdeadbeef;
      endcase
   endfunction

   task automatic writeReg(input logic [4:0] rd, input logic [31:0] v);
      if (rd != 5'd0) begin
         mReg[rd] = v;
         expWrites.push_back({rd, v});
      end
   endtask

   // architectural RV32I model, runs until ecall
   task automatic runModel();
      logic [31:0] w, pc, nextPc, a, b, t, immI, immS, immB, immJ;
      logic [4:0] rd;
      logic [2:0] f3;
      logic taken;
      int steps;
      pc = 0;
      mCount = 0;
      for (steps = 0; steps < 2000; steps++) begin
         w = imem[pc[addrW-1:2]];
         rd = w[11:7];
         f3 = w[14:12];
         a = (w[19:15] == 5'd0) ? 32'd0 : mReg[w[19:15]];
         b = (w[24:20] == 5'd0) ? 32'd0 : mReg[w[24:20]];
         immI = {{20{w[31]}}, w[31:20]};
         immS = {{20{w[31]}}, w[31:25], w[11:7]};
         immB = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
         immJ = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
         nextPc = pc + 32'd4;
         if (w[6:0] == opSystem) begin
            return;
         end
         case (w[6:0])
            opOp: writeReg(rd, aluRef(f3, w[30], a, b));
            opOpImm: writeReg(rd, aluRef(f3, 1'b0, a, immI));
            opLui: writeReg(rd, {w[31:12], 12'b0});
            opLoad: writeReg(rd, mMem[((a + immI) >> 2) % dDepth]);
            opStore: mMem[((a + immS) >> 2) % dDepth] = b;
            opBranch: begin
               taken = (f3 == 3'b000) ? (a == b) :
                       (f3 == 3'b001) ? (a != b) : ($signed(a) < $signed(b));
               if (taken) begin
                  nextPc = pc + immB;
               end
            end
            opJal: begin
               writeReg(rd, pc + 32'd4);
               nextPc = pc + immJ;
            end
            opJalr: begin
               t = (a + immI) & ~32'd1;
               writeReg(rd, pc + 32'd4);
               nextPc = t;
            end
            default: noteFail("reference model met an opcode outside the subset");
         endcase
         mCount++;
         pc = nextPc;
      end
      noteFail("reference model never reached ecall");
   endtask

   // ecall, then instructions that must never take effect
   task automatic endProgram();
      prog.push_back(32'h00000073);
      prog.push_back(encI(77, 9, 0, 9, opOpImm));
      prog.push_back(encS(8, 9, 0));
      prog.push_back(encS(12, 9, 0));
      prog.push_back(encI(5, 0, 0, 3, opOpImm));
   endtask

   task automatic buildAlu();
      logic [4:0] rd, rs1, lastRd;
      int kind;
      lastRd = 5'd1;
      for (int i = 1; i <= 8; i++) begin
         prog.push_back(encI(int'(nextRand() % 4096), 0, 0, i, opOpImm));
      end
      // back-to-back chains hit both forwarding paths and the decode bypass
      for (int i = 0; i < 24; i++) begin
         rd = randReg(1, 8);
         rs1 = (i % 2 == 0) ? lastRd : randReg(1, 8);
         kind = int'(nextRand() % 12);
         if (kind < 6) begin
            prog.push_back(encR(kind == 1 ? 32 : 0, randReg(1, 8), rs1,
                                kind == 0 || kind == 1 ? 0 : (kind == 2 ? 7 :
                                kind == 3 ? 6 : kind == 4 ? 4 : 2), rd));
         end else if (kind < 11) begin
            prog.push_back(encI(int'(nextRand() % 4096), rs1,
                                kind == 6 ? 0 : kind == 7 ? 7 : kind == 8 ? 6 :
                                kind == 9 ? 4 : 2, rd, opOpImm));
         end else begin
            prog.push_back({20'(nextRand()), rd, opLui});
         end
         lastRd = rd;
      end
      endProgram();
   endtask

   task automatic buildMem();
      prog.push_back(encI(256, 0, 0, 10, opOpImm));
      for (int k = 0; k < 6; k++) begin
         prog.push_back(encS(k * 4, 1 + k, 10));
      end
      prog.push_back(encI(int'(nextRand() % 4096), 0, 0, 7, opOpImm));
      prog.push_back(encS(40, 7, 10));
      for (int k = 0; k < 6; k++) begin
         prog.push_back(encI(k * 4, 10, 2, 16 + k, opLoad));
         prog.push_back(encI(1, 25, 0, 25, opOpImm));
         prog.push_back(encR(0, 26, 16 + k, 0, 26));
      end
      // untouched word still holds the fill pattern
      prog.push_back(encI(64, 10, 2, 22, opLoad));
      prog.push_back(encI(1, 25, 0, 25, opOpImm));
      prog.push_back(encS(44, 22, 10));
      prog.push_back(encI(40, 10, 2, 23, opLoad));
      prog.push_back(encI(1, 25, 0, 25, opOpImm));
      prog.push_back(encR(32, 23, 26, 0, 24));
      endProgram();
   endtask

   task automatic buildBranch();
      for (int k = 0; k < 9; k++) begin
         prog.push_back(encI(int'(nextRand() % 4096), 0, 0, 11, opOpImm));
         if (k % 2 == 0) begin
            prog.push_back(encR(0, 0, 11, 0, 12));
         end else if (k == 5) begin
            // second operand one above the first so blt is taken
            prog.push_back(encI(1, 11, 0, 12, opOpImm));
         end else begin
            prog.push_back(encI(int'(nextRand() % 4096), 0, 0, 12, opOpImm));
         end
         prog.push_back(encB(12, 12, 11, k % 3 == 0 ? 0 : (k % 3 == 1 ? 1 : 4)));
         prog.push_back(encI(1, 13, 0, 13, opOpImm));
         prog.push_back(encS(8, 13, 0));
         prog.push_back(encI(k + 1, 14, 0, 14, opOpImm));
      end
      endProgram();
   endtask

   task automatic buildJump();
      int p;
      for (int j = 0; j < 3; j++) begin
         prog.push_back(encJ(12, 1 + j));
         prog.push_back(encI(3, 2, 0, 2, opOpImm));
         prog.push_back(encS(12, 2, 0));
         prog.push_back(encR(0, 0, 1 + j, 0, 5 + j));
         // odd sum checks that jalr clears bit 0
         p = prog.size();
         prog.push_back(encI((p + 4) * 4 - 6, 0, 0, 10, opOpImm));
         prog.push_back(encI(7, 10, 0, 11 + j, opJalr));
         prog.push_back(encI(3, 2, 0, 2, opOpImm));
         prog.push_back(encS(12, 2, 0));
         prog.push_back(encR(0, 10, 11 + j, 0, 15 + j));
      end
      endProgram();
   endtask

   task automatic resetDut();
      @(posedge clk);
      rstN <= 1'b0;
      @(negedge clk);
      checkValue("halt", 32'd0, 32'(halt));
      checkValue("rfWe", 32'd0, 32'(rfWe));
      checkValue("dMemWen", 32'd0, 32'(dMemWen));
      checkValue("numInst", 32'd0, numInst);
      checkValue("iMemAddr", 32'd0, 32'(iMemAddr));
      checkValue("iMemCsN", 32'd1, 32'(iMemCsN));
      checkValue("dMemCsN", 32'd1, 32'(dMemCsN));
      @(posedge clk);
      @(posedge clk);
      rstN <= 1'b1;
   endtask

   task automatic runTest(input string name);
      int errBefore, start;
      errBefore = errors;
      limit = limit + prog.size() + 10;
      for (int i = 0; i < iDepth; i++) begin
         imem[i] = (i < prog.size()) ? prog[i] : 32'd0;
      end
      for (int i = 0; i < dDepth; i++) begin
         dmem[i] = 32'(i) * 32'h01000193 ^ 32'hc3a50000;
         mMem[i] = dmem[i];
      end
      rf[0] = 32'd0;
      for (int i = 1; i < 32; i++) begin
         rf[i] = nextRand();
      end
      mReg = rf;
      expWrites.delete();
      runModel();
      start = cycles;
      resetDut();
      while (!halt) begin
         @(posedge clk);
      end
      // let the instructions behind ecall reach write-back
      repeat (3) @(posedge clk);
      @(negedge clk);
      checkValue("iMemCsN", 32'd0, 32'(iMemCsN));
      checkValue("dMemCsN", 32'd0, 32'(dMemCsN));
      for (int i = 1; i < 32; i++) begin
         checkValue($sformatf("x%0d", i), mReg[i], rf[i]);
      end
      for (int i = 0; i < dDepth; i++) begin
         checkValue($sformatf("dmem[%0d]", i), mMem[i], dmem[i]);
      end
      checkValue("numInst", 32'(mCount), numInst);
      if (expWrites.size() != 0) begin
         noteFail($sformatf("%0d expected register writes never happened", expWrites.size()));
      end
      testsRun++;
      $display("%s: %0d cycles, %0d errors", name, cycles - start, errors - errBefore);
      prog.delete();
   endtask

   initial begin
      rstN = 1'b0;
      rngState = 32'd74;
      errors = 0;
      cycles = 0;
      limit = 0;
      testsRun = 0;
      buildAlu();
      runTest("alu chain");
      buildMem();
      runTest("store and load");
      buildBranch();
      runTest("branches");
      buildJump();
      runTest("jumps");
      $display("%0d tests run, %0d errors", testsRun, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: all.f
rvPkg.sv
fwdIf.sv
rvDecode.sv
rvAlu.sv
rvForward.sv
rvRunCtrl.sv
rvDatapath.sv
rvTop.sv
tbTop.sv

// File: Makefile
TOP ?= tbTop
BUILD ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
FILELIST ?= all.f

.PHONY: build run clean

build:
	verilator $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: build
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test passed"

clean:
	rm -rf $(BUILD)
